/* bench/core_stim.txt */
# M <address> <word>                  preloaded memory word
# W <test> <address> <data> <mask>    expected store, in order
M 80000000 800000B7   # lui   x1, 0x80000
M 80000004 0C008093   # addi  x1, x1, 0xc0
M 80000008 FFB00113   # addi  x2, x0, -5
M 8000000C 0020A023   # sw    x2, 0(x1)
M 80000010 123451B7   # lui   x3, 0x12345
M 80000014 0030A223   # sw    x3, 4(x1)
M 80000018 00001217   # auipc x4, 0x1
M 8000001C 0040A423   # sw    x4, 8(x1)
M 80000020 A1B2C2B7   # lui   x5, 0xa1b2c
M 80000024 3D428293   # addi  x5, x5, 0x3d4
M 80000028 00508823   # sb    x5, 16(x1)
M 8000002C 005088A3   # sb    x5, 17(x1)
M 80000030 00508923   # sb    x5, 18(x1)
M 80000034 005089A3   # sb    x5, 19(x1)
M 80000038 00509A23   # sh    x5, 20(x1)
M 8000003C 00509B23   # sh    x5, 22(x1)
M 80000040 03808303   # lb    x6, 56(x1)
M 80000044 0060AC23   # sw    x6, 24(x1)
M 80000048 03B0C303   # lbu   x6, 59(x1)
M 8000004C 0060AE23   # sw    x6, 28(x1)
M 80000050 03A09303   # lh    x6, 58(x1)
M 80000054 0260A023   # sw    x6, 32(x1)
M 80000058 03A0D303   # lhu   x6, 58(x1)
M 8000005C 0260A223   # sw    x6, 36(x1)
M 80000060 0380A303   # lw    x6, 56(x1)
M 80000064 0260A423   # sw    x6, 40(x1)
M 80000068 008003EF   # jal   x7, +8
M 8000006C 0200AE23   # sw    x0, 60(x1), skipped
M 80000070 0270A623   # sw    x7, 44(x1)
M 80000074 00000417   # auipc x8, 0
M 80000078 00D404E7   # jalr  x9, 13(x8)
M 8000007C 0200AE23   # sw    x0, 60(x1), skipped
M 80000080 0290A823   # sw    x9, 48(x1)
M 80000084 0000006F   # jal   x0, 0
M 800000F8 81F27A95   # load source word
W 2 800000C0 FFFFFFFB F
W 2 800000C4 12345000 F
W 2 800000C8 80001018 F
W 3 800000D0 D4D4D4D4 1
W 3 800000D1 D4D4D4D4 2
W 3 800000D2 D4D4D4D4 4
W 3 800000D3 D4D4D4D4 8
W 3 800000D4 C3D4C3D4 3
W 3 800000D6 C3D4C3D4 C
W 4 800000D8 FFFFFF95 F
W 4 800000DC 00000081 F
W 4 800000E0 FFFF81F2 F
W 4 800000E4 000081F2 F
W 4 800000E8 81F27A95 F
W 5 800000EC 8000006C F
W 5 800000F0 8000007C F

/* src.f */
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
bench/tb_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_core
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_core.sv */
`timescale 1ns/1ns

module tb_core;

  localparam logic [31:0] RESET_PC = 32'h8000_0000;

  logic             clk;
  logic             rst_n;
  rv_pkg::mem_req_t mem_req;
  logic             mem_req_valid;
  logic             mem_req_ready;
  rv_pkg::mem_rsp_t mem_rsp;
  logic             mem_rsp_valid;

  logic [31:0]      mem [64];   // 64-word window at RESET_PC
  logic [31:0]      exp_addr [$];
  logic [31:0]      exp_data [$];
  logic [3:0]       exp_mask [$];
  int               exp_test [$];
  int               w_last [2:5]; // index of the last store of each test
  int               w_idx;
  int               m_count;
  int               err_cnt [1:6];
  int               stall_cnt;
  logic             loaded;
  logic             first_seen;
  rv_pkg::mem_req_t first_req;
  logic [15:0]      lfsr;
  string            test_name [1:6];

  rv_core #(
    .RESET_PC   (RESET_PC),
    .REG_ADDR_W (5)
  ) rv_core_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp       (mem_rsp),
    .mem_rsp_valid (mem_rsp_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    return b;
  endfunction

  // load opcode with a width the core executes
  function automatic logic is_load(input logic [31:0] word);
    return (word[6:0] == 7'b000_0011) &&
           (word[14:12] inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
  endfunction

  task automatic load_stim();
    int           fd;
    int           code;
    int           t;
    logic [7:0]   tag;
    logic [31:0]  a;
    logic [31:0]  d;
    logic [3:0]   m;
    logic [799:0] rest;
    for (int i = 0; i < 64; i++) begin
      mem[i] = ~(RESET_PC + 32'(4 * i)); // fill follows the word address
    end
    fd = $fopen("bench/core_stim.txt", "r");
    assert (fd != 0) else begin
      $display("could not open the stimulus file bench/core_stim.txt");
      err_cnt[6]++;
    end
    if (fd != 0) begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "M") begin
          code = $fscanf(fd, "%h %h", a, d);
          assert (code == 2) else begin
            $display("short M line in the stimulus file");
            err_cnt[6]++;
          end
          mem[a[7:2]] = d;
          m_count++;
        end else if (tag == "W") begin
          code = $fscanf(fd, "%d %h %h %h", t, a, d, m);
          assert (code == 4) else begin
            $display("short W line in the stimulus file");
            err_cnt[6]++;
          end
          exp_test.push_back(t);
          exp_addr.push_back(a);
          exp_data.push_back(d);
          exp_mask.push_back(m);
          if (t >= 2 && t <= 5) w_last[t] = exp_addr.size() - 1;
        end else begin
          code = $fgets(rest, fd); // rest of a comment
        end
      end
      $fclose(fd);
    end
  endtask

  // compare one accepted write with the next expected store, then apply it
  task automatic score_store(input rv_pkg::mem_req_t req);
    int   t;
    logic hit;
    t   = (w_idx < exp_addr.size()) ? exp_test[w_idx] : 6;
    hit = (w_idx < exp_addr.size()) && (req.addr == exp_addr[w_idx]);
    assert (hit) else begin
      $display("unexpected write at %0t ns to %h with data %h and mask %h",
               $time, req.addr, req.wdata, req.wmask);
      err_cnt[t]++;
    end
    if (hit) begin
      assert (req.wdata == exp_data[w_idx]) else begin
        $display("FAIL at %0t ns: mem_req.wdata = %h, expected %h",
                 $time, req.wdata, exp_data[w_idx]);
        err_cnt[t]++;
      end
      assert (req.wmask == exp_mask[w_idx]) else begin
        $display("FAIL at %0t ns: mem_req.wmask = %h, expected %h",
                 $time, req.wmask, exp_mask[w_idx]);
        err_cnt[t]++;
      end
      w_idx++;
    end
    for (int b = 0; b < 4; b++) begin
      if (req.wmask[b]) mem[req.addr[7:2]][8*b +: 8] = req.wdata[8*b +: 8];
    end
  endtask

  // fetch addresses are word aligned
  task automatic check_fetch(input logic [31:0] addr);
    int t;
    t = (w_idx < exp_addr.size()) ? exp_test[w_idx] : 6;
    assert (addr[1:0] == 2'b00) else begin
      $display("FAIL at %0t ns: fetch mem_req.addr[1:0] = %b, expected 00",
               $time, addr[1:0]);
      err_cnt[t]++;
    end
  endtask

  task automatic expect_idle(input string when_txt);
    assert (mem_req_valid == 1'b0) else begin
      $display("FAIL at %0t ns: mem_req_valid = %b, expected 0 (%s)",
               $time, mem_req_valid, when_txt);
      err_cnt[1]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %s, %0d errors", t, test_name[t],
             (err_cnt[t] == 0) ? "passed" : "failed", err_cnt[t]);
  endtask

  // memory model with random ready and 1 to 3 cycles of read latency
  initial begin : mem_model
    logic             seen_valid;
    rv_pkg::mem_req_t seen;
    logic             pending;
    int               wait_cnt;
    logic [31:0]      rd_word;
    logic             b0;
    logic             b1;
    logic             load_next;
    lfsr          = 16'd17649;
    mem_req_ready = 1'b0;
    mem_rsp       = '0;
    mem_rsp_valid = 1'b0;
    first_seen    = 1'b0;
    first_req     = '0;
    stall_cnt     = 0;
    w_idx         = 0;
    pending       = 1'b0;
    wait_cnt      = 0;
    rd_word       = '0;
    load_next     = 1'b0;
    forever begin
      @(negedge clk); // request is stable here
      seen_valid = mem_req_valid;
      seen       = mem_req;
      @(posedge clk);
      #1;
      mem_rsp_valid = 1'b0;
      if (seen_valid === 1'b1) begin
        if (!first_seen) begin
          first_seen = 1'b1;
          first_req  = seen;
        end
        if (!mem_req_ready) begin
          stall_cnt++;
        end else if (seen.we) begin
          score_store(seen);
        end else begin
          if (!load_next) begin
            check_fetch(seen.addr);
          end
          b0       = next_bit();
          b1       = next_bit();
          wait_cnt = (b0 ? 1 : 0) + (b1 ? 1 : 0);
          pending  = 1'b1;
          rd_word  = mem[seen.addr[7:2]];
          load_next = !load_next && is_load(rd_word); // data read follows a load
        end
      end
      if (pending) begin
        if (wait_cnt == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rsp.rdata = rd_word;
          pending       = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      b0            = next_bit();
      b1            = next_bit();
      mem_req_ready = b0 | b1; // low about one cycle in four
    end
  end

  initial begin : watchdog
    while (loaded !== 1'b1) @(posedge clk);
    repeat (40 * m_count + 200) @(posedge clk);
    $display("timeout: %0d of %0d expected stores seen", w_idx, exp_addr.size());
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int total;
    int n_fail;
    rst_n   = 1'b0;
    loaded  = 1'b0;
    m_count = 0;
    for (int t = 1; t <= 6; t++) err_cnt[t] = 0;
    for (int t = 2; t <= 5; t++) w_last[t] = -1;
    test_name[1] = "reset and first fetch";
    test_name[2] = "addi lui auipc";
    test_name[3] = "sb sh lanes";
    test_name[4] = "loads";
    test_name[5] = "jal jalr";
    test_name[6] = "stalls and store order";
    load_stim();
    loaded = 1'b1;

    repeat (2) begin
      @(posedge clk);
      #1;
      expect_idle("in reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    expect_idle("first cycle after reset");
    while (!first_seen) @(posedge clk);
    assert (first_req.addr == RESET_PC && !first_req.we) else begin
      $display("FAIL at %0t ns: first mem_req.addr = %h we = %b, expected %h we = 0",
               $time, first_req.addr, first_req.we, RESET_PC);
      err_cnt[1]++;
    end
    report_test(1);

    for (int t = 2; t <= 5; t++) begin
      while (w_idx <= w_last[t]) @(posedge clk);
      report_test(t);
    end
    while (w_idx < exp_addr.size()) @(posedge clk);
    repeat (30) @(posedge clk); // room for a stray store
    assert (stall_cnt > 0) else begin
      $display("ready was never low while a request was waiting");
      err_cnt[6]++;
    end
    report_test(6);

    total  = 0;
    n_fail = 0;
    for (int t = 1; t <= 6; t++) begin
      total += err_cnt[t];
      if (err_cnt[t] != 0) n_fail++;
    end
    $display("6 tests, %0d failed, %0d errors, %0d stall cycles", n_fail, total, stall_cnt);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ns

module rv_core #(
  parameter logic [31:0] RESET_PC   = 32'h8000_0000,
  parameter int          REG_ADDR_W = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  output rv_pkg::mem_req_t mem_req,
  output logic             mem_req_valid,
  input  logic             mem_req_ready,
  input  rv_pkg::mem_rsp_t mem_rsp,
  input  logic             mem_rsp_valid
);

  typedef enum logic [1:0] {
    S_FETCH = 2'd0,
    S_EXEC  = 2'd1,
    S_MEM   = 2'd2
  } state_e;

  state_e                  state;
  logic                    started;  // low for the first cycle out of reset
  logic                    rsp_wait; // read accepted, data not back yet
  logic [rv_pkg::XLEN-1:0] pc;
  logic [rv_pkg::XLEN-1:0] ir;

  logic [REG_ADDR_W-1:0]   rs1_addr;
  logic [REG_ADDR_W-1:0]   rs2_addr;
  logic [REG_ADDR_W-1:0]   rd_addr;
  logic [rv_pkg::XLEN-1:0] imm;
  rv_pkg::ctrl_t           ctrl;
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] sum;
  logic [rv_pkg::XLEN-1:0] pc_plus4;
  logic [rv_pkg::XLEN-1:0] next_pc;
  logic [rv_pkg::XLEN-1:0] wb_data;
  logic [rv_pkg::XLEN-1:0] lsu_wdata;
  logic [3:0]              lsu_wmask;
  logic [rv_pkg::XLEN-1:0] load_data;
  logic                    is_jalr;
  logic                    mem_op;
  logic                    req_fire;
  logic                    rsp_fire;
  logic                    rf_we;

  rv_decode rv_decode_inst (
    .instr    (ir),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .imm      (imm),
    .ctrl     (ctrl)
  );

  rv_regfile #(
    .REG_ADDR_W (REG_ADDR_W)
  ) rv_regfile_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .we       (rf_we),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_lsu rv_lsu_inst (
    .funct3     (ctrl.funct3),
    .addr_lo    (sum[1:0]),
    .store_data (rs2_data),
    .load_word  (mem_rsp.rdata),
    .wdata      (lsu_wdata),
    .wmask      (lsu_wmask),
    .load_data  (load_data)
  );

  assign pc_plus4 = pc + 32'd4;
  assign op_a     = (ctrl.op_a_pc == rv_pkg::OPA_PC) ? pc : rs1_data;
  assign sum      = op_a + imm; // alu result, jump target and mem address

  assign is_jalr  = (ir[6:0] == rv_pkg::JALR);
  assign next_pc  = ctrl.next_from_adder ? {sum[31:1], sum[0] & ~is_jalr} : pc_plus4;

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_PC4:  wb_data = pc_plus4;
      rv_pkg::WB_LOAD: wb_data = load_data;
      default:         wb_data = sum;
    endcase
  end

  assign mem_op   = ctrl.mem_rd | ctrl.mem_wr;
  assign mem_req_valid = started && !rsp_wait && (state == S_FETCH || state == S_MEM);
  assign req_fire = mem_req_valid && mem_req_ready;
  assign rsp_fire = rsp_wait && mem_rsp_valid;

  // loads write back when their data returns, everything else in exec
  assign rf_we = ctrl.reg_we &&
                 ((state == S_EXEC && !ctrl.mem_rd) || (state == S_MEM && rsp_fire));

  always_comb begin
    if (state == S_MEM) begin
      mem_req.addr  = sum;
      mem_req.wdata = lsu_wdata;
      mem_req.wmask = ctrl.mem_wr ? lsu_wmask : 4'b0000;
      mem_req.we    = ctrl.mem_wr;
    end else begin // instruction fetch
      mem_req.addr  = pc;
      mem_req.wdata = '0;
      mem_req.wmask = 4'b0000;
      mem_req.we    = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_FETCH;
      started  <= 1'b0;
      rsp_wait <= 1'b0;
      pc       <= RESET_PC;
    end else begin
      started <= 1'b1;
      case (state)
        S_FETCH: begin
          if (req_fire) begin
            rsp_wait <= 1'b1;
          end else if (rsp_fire) begin
            rsp_wait <= 1'b0;
            state    <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (mem_op) begin
            state <= S_MEM;
          end else begin
            pc    <= next_pc;
            state <= S_FETCH;
          end
        end
        S_MEM: begin
          if (req_fire && ctrl.mem_wr) begin // store done at acceptance
            pc    <= pc_plus4;
            state <= S_FETCH;
          end else if (req_fire) begin
            rsp_wait <= 1'b1;
          end else if (rsp_fire) begin
            rsp_wait <= 1'b0;
            pc       <= pc_plus4;
            state    <= S_FETCH;
          end
        end
        default: state <= S_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH && rsp_fire) begin
      ir <= mem_rsp.rdata;
    end
  end

endmodule

/* hdl/rv_lsu.sv */
`timescale 1ns/1ns

module rv_lsu (
  input  logic [2:0]              funct3,
  input  logic [1:0]              addr_lo,
  input  logic [rv_pkg::XLEN-1:0] store_data,
  input  logic [rv_pkg::XLEN-1:0] load_word,
  output logic [rv_pkg::XLEN-1:0] wdata,
  output logic [3:0]              wmask,
  output logic [rv_pkg::XLEN-1:0] load_data
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic        half_ok;
  logic        word_ok;

  assign half_ok = ~addr_lo[0];
  assign word_ok = (addr_lo == 2'b00);

  // addressed lane of the returned word
  assign ld_byte = load_word[8*addr_lo +: 8];
  assign ld_half = addr_lo[1] ? load_word[31:16] : load_word[15:0];

  // store side, data replicated over all lanes and the mask picks the lane
  always_comb begin
    wdata = store_data;
    wmask = 4'b0000;
    case (funct3)
      rv_pkg::F3_BYTE: begin
        wdata = {4{store_data[7:0]}};
        wmask = 4'b0001 << addr_lo;
      end
      rv_pkg::F3_HALF: begin
        wdata = {2{store_data[15:0]}};
        if (half_ok) begin
          wmask = addr_lo[1] ? 4'b1100 : 4'b0011;
        end
      end
      rv_pkg::F3_WORD: begin
        if (word_ok) begin
          wmask = 4'b1111;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    load_data = '0;
    case (funct3)
      rv_pkg::F3_BYTE:   load_data = {{24{ld_byte[7]}}, ld_byte};
      rv_pkg::F3_BYTE_U: load_data = {24'h000000, ld_byte};
      rv_pkg::F3_HALF: begin
        if (half_ok) load_data = {{16{ld_half[15]}}, ld_half};
      end
      rv_pkg::F3_HALF_U: begin
        if (half_ok) load_data = {16'h0000, ld_half};
      end
      rv_pkg::F3_WORD: begin
        if (word_ok) load_data = load_word;
      end
      default: ;
    endcase
  end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile #(
  parameter int REG_ADDR_W = 5
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [REG_ADDR_W-1:0]   rs1_addr,
  input  logic [REG_ADDR_W-1:0]   rs2_addr,
  input  logic [REG_ADDR_W-1:0]   rd_addr,
  input  logic                    we,
  input  logic [rv_pkg::XLEN-1:0] wdata,
  output logic [rv_pkg::XLEN-1:0] rs1_data,
  output logic [rv_pkg::XLEN-1:0] rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [2**REG_ADDR_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin // x0 stays zero
      regs[rd_addr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hdl/rv_decode.sv */
`timescale 1ns/1ns

module rv_decode (
  input  logic [31:0]              instr,
  output logic [4:0]               rs1_addr,
  output logic [4:0]               rs2_addr,
  output logic [4:0]               rd_addr,
  output logic [rv_pkg::XLEN-1:0]  imm,
  output rv_pkg::ctrl_t            ctrl
);

  rv_pkg::opcode_e         opcode;
  logic [2:0]              funct3;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_s;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic                    legal_ld;
  logic                    legal_st;

  assign opcode   = rv_pkg::opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];

  // lui carries immediate bits in the rs1 field, so read x0 instead
  assign rs1_addr = (opcode == rv_pkg::LUI) ? 5'd0 : instr[19:15];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  assign legal_ld = funct3 inside {rv_pkg::F3_BYTE, rv_pkg::F3_HALF, rv_pkg::F3_WORD,
                                   rv_pkg::F3_BYTE_U, rv_pkg::F3_HALF_U};
  assign legal_st = funct3 inside {rv_pkg::F3_BYTE, rv_pkg::F3_HALF, rv_pkg::F3_WORD};

  always_comb begin
    imm                  = '0;
    ctrl.op_a_pc         = rv_pkg::OPA_RS1;
    ctrl.wb_sel          = rv_pkg::WB_ADDER;
    ctrl.reg_we          = 1'b0;
    ctrl.mem_rd          = 1'b0;
    ctrl.mem_wr          = 1'b0;
    ctrl.next_from_adder = 1'b0;
    ctrl.funct3          = funct3;
    case (opcode)
      rv_pkg::OP_IMM: begin
        if (funct3 == 3'b000) begin // addi only
          imm         = imm_i;
          ctrl.reg_we = 1'b1;
        end
      end
      rv_pkg::AUIPC: begin
        imm          = imm_u;
        ctrl.op_a_pc = rv_pkg::OPA_PC;
        ctrl.reg_we  = 1'b1;
      end
      rv_pkg::LUI: begin
        imm         = imm_u; // x0 + imm
        ctrl.reg_we = 1'b1;
      end
      rv_pkg::JAL: begin
        imm                  = imm_j;
        ctrl.op_a_pc         = rv_pkg::OPA_PC;
        ctrl.wb_sel          = rv_pkg::WB_PC4;
        ctrl.reg_we          = 1'b1;
        ctrl.next_from_adder = 1'b1;
      end
      rv_pkg::JALR: begin
        imm                  = imm_i;
        ctrl.wb_sel          = rv_pkg::WB_PC4;
        ctrl.reg_we          = 1'b1;
        ctrl.next_from_adder = 1'b1;
      end
      rv_pkg::LOAD: begin
        if (legal_ld) begin
          imm         = imm_i;
          ctrl.wb_sel = rv_pkg::WB_LOAD;
          ctrl.reg_we = 1'b1;
          ctrl.mem_rd = 1'b1;
        end
      end
      rv_pkg::STORE: begin
        if (legal_st) begin
          imm         = imm_s;
          ctrl.mem_wr = 1'b1;
        end
      end
      default: ; // no-op, pc + 4 only
    endcase
  end

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;

  // base opcodes handled by the core
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    AUIPC  = 7'b001_0111,
    LUI    = 7'b011_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011
  } opcode_e;

  // adder operand a source
  typedef enum logic {
    OPA_RS1 = 1'b0,
    OPA_PC  = 1'b1
  } imm_sel_e;

  typedef enum logic [1:0] {
    WB_ADDER = 2'd0,
    WB_PC4   = 2'd1, // link value for jal/jalr
    WB_LOAD  = 2'd2
  } wb_sel_e;

  // load/store width codes
  localparam logic [2:0] F3_BYTE   = 3'b000;
  localparam logic [2:0] F3_HALF   = 3'b001;
  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_BYTE_U = 3'b100;
  localparam logic [2:0] F3_HALF_U = 3'b101;

  typedef struct packed {
    imm_sel_e   op_a_pc;
    wb_sel_e    wb_sel;
    logic       reg_we;
    logic       mem_rd;
    logic       mem_wr;
    logic       next_from_adder; // jump target comes from the adder
    logic [2:0] funct3;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [3:0]      wmask;
    logic            we;
  } mem_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

endpackage
